//--- testbench/stim_snn.txt
# N name | W pre post weight | S pre | T step marker
# E out_addr hex, step in [5:4], neuron in [2:0] | G goodness decimal
N sub_threshold_inhibit
W 0 5 30
W 1 2 70
W 2 2 -70
S 0
S 0      # n5 at 60
S 1
S 2      # n2 nets to 0
T
T
T
T
G 0
N threshold_isolation
W 1 6 40
W 2 7 64
S 0      # n5 at 30 only if cleared
S 1
T
E 002
S 1
T
E 012
E 016
S 2
T
E 027    # n7 exactly at threshold
T
G 6
N burst_backpressure
W 3 1 64
W 3 4 64
S 3
S 3
S 0
T
S 3
T
S 3
T
S 3
T
E 001
E 004
E 011
E 014
E 021
E 024
E 031
E 034
G 32

//--- list.f
design/snn_pkg.sv
design/aer_in_receiver.sv
design/event_fifo.sv
design/synapse_mem.sv
design/snn_controller.sv
design/neuron_array.sv
design/aer_out_sender.sv
design/snn_core_top.sv
testbench/tb_snn_core.sv

//--- Bender.yml
package:
  name: snn_core

sources:
  - design/snn_pkg.sv
  - design/aer_in_receiver.sv
  - design/event_fifo.sv
  - design/synapse_mem.sv
  - design/snn_controller.sv
  - design/neuron_array.sv
  - design/aer_out_sender.sv
  - design/snn_core_top.sv
  - target: simulation
    files:
      - testbench/tb_snn_core.sv

//--- testbench/tb_snn_core.sv
`timescale 1ns/100ps

module tb_snn_core;
    import snn_pkg::*;

    localparam int WAIT_LIMIT = 2000;   // cycles allowed per wait

    logic       CLK = 1'b0;
    logic       reset;
    aer_addr_t  aerin_addr;
    logic       aerin_req;
    logic       aerin_ack;
    logic       prog_we;
    pre_addr_t  prog_pre;
    post_addr_t prog_post;
    weight_t    prog_weight;
    aer_addr_t  aerout_addr;
    logic       aerout_req;
    logic       aerout_ack = 1'b0;
    goodness_t  goodness;
    logic       sample_done;

    aer_addr_t  out_q[$];               // output events as acked
    goodness_t  good_q[$];              // goodness seen at each sample_done
    int         seed = 32'h4a33;
    int         ack_wait;
    logic       ack_armed = 1'b0;
    int         errors = 0;
    int         test_errors = 0;
    int         tests = 0;
    int         failed_tests = 0;
    int         checks = 0;
    logic       timed_out = 1'b0;
    string      test_name;

    snn_core_top dut_i (.*);

    always #5 CLK = ~CLK;

    // ------------------------------------------------------------------
    // output link receiver, acks after 0..3 cycles
    // ------------------------------------------------------------------
    always @(negedge CLK) begin
        if (reset) begin
            aerout_ack = 1'b0;
            ack_armed  = 1'b0;
        end else if (aerout_ack) begin
            if (!aerout_req) aerout_ack = 1'b0;   // return to zero
        end else if (aerout_req) begin
            if (!ack_armed) begin
                ack_wait  = $unsigned($random(seed)) % 4;
                ack_armed = 1'b1;
            end
            if (ack_wait == 0) begin
                out_q.push_back(aerout_addr);     // addr stable while req
                aerout_ack = 1'b1;
                ack_armed  = 1'b0;
            end else begin
                ack_wait--;
            end
        end
        if (sample_done) good_q.push_back(goodness);
    end

    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        record_error();
        timed_out = 1'b1;                  // stops the command loop
    endtask

    // field count of one stim line
    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            $display("Error at %0t: malformed stim line, %0d of %0d fields read",
                     $time, got, want);
            record_error();
        end
    endtask

    // all outputs idle once reset is released
    task automatic check_reset_state();
        checks++;
        if (aerin_ack !== 1'b0) begin
            $display("Fail at %0t: aerin_ack expected 0 got %b", $time, aerin_ack);
            record_error();
        end
        if (aerout_req !== 1'b0) begin
            $display("Fail at %0t: aerout_req expected 0 got %b", $time, aerout_req);
            record_error();
        end
        if (sample_done !== 1'b0) begin
            $display("Fail at %0t: sample_done expected 0 got %b", $time, sample_done);
            record_error();
        end
        if (goodness !== goodness_t'(0)) begin
            $display("Fail at %0t: goodness expected 0 got %0d", $time, goodness);
            record_error();
        end
    endtask

    task automatic program_weight(input int pre, input int post, input int w);
        @(negedge CLK);
        prog_we     = 1'b1;
        prog_pre    = pre_addr_t'(pre);
        prog_post   = post_addr_t'(post);
        prog_weight = weight_t'(w);
        @(negedge CLK);
        prog_we = 1'b0;
    endtask

    // synapse memory has no reset
    task automatic clear_weights();
        for (int p = 0; p < N_PRE; p++)
            for (int q = 0; q < N_POST; q++)
                program_weight(p, q, 0);
    endtask

    // one four-phase input event
    task automatic send_input(input aer_addr_t addr);
        int n;
        @(negedge CLK);
        aerin_addr = addr;
        aerin_req  = 1'b1;
        n = 0;
        while (!aerin_ack && n < WAIT_LIMIT) begin   // held off while fifo full
            @(negedge CLK);
            n++;
        end
        aerin_req = 1'b0;
        if (!aerin_ack) begin
            report_timeout("input ack never rose");
        end else begin
            n = 0;
            while (aerin_ack && n < WAIT_LIMIT) begin
                @(negedge CLK);
                n++;
            end
            if (aerin_ack) report_timeout("input ack never fell");
        end
    endtask

    task automatic expect_event(input aer_addr_t exp);
        int n;
        aer_addr_t got;
        n = 0;
        while (out_q.size() == 0 && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        checks++;
        if (out_q.size() == 0) begin
            report_timeout("expected output event never arrived");
        end else begin
            got = out_q.pop_front();
            if (got !== exp) begin
                $display("Fail at %0t: aerout_addr expected %h got %h", $time, exp, got);
                record_error();
            end
        end
    endtask

    // goodness, then nothing left over from this sample
    task automatic expect_goodness(input int exp);
        int n;
        goodness_t got;
        n = 0;
        while (good_q.size() == 0 && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        checks++;
        if (good_q.size() == 0) begin
            report_timeout("sample_done never pulsed");
        end else begin
            got = good_q.pop_front();
            if (got !== goodness_t'(exp)) begin
                $display("Fail at %0t: goodness expected %0d got %0d", $time, exp, got);
                record_error();
            end
            if (out_q.size() != 0) begin
                $display("Error at %0t: %0d output events more than expected",
                         $time, out_q.size());
                record_error();
                out_q.delete();
            end
        end
    endtask

    task automatic close_test();
        if (tests > 0) begin
            if (test_errors == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: %0d errors", test_name, test_errors);
                failed_tests++;
            end
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------------------------
    // command loop over the stim file
    // ------------------------------------------------------------------
    initial begin
        int fd;
        int cnt;
        int cmd;
        int a1, a2, a3;
        reset       = 1'b1;
        aerin_addr  = '0;
        aerin_req   = 1'b0;
        prog_we     = 1'b0;
        prog_pre    = '0;
        prog_post   = '0;
        prog_weight = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        check_reset_state();
        clear_weights();
        fd = $fopen("testbench/stim_snn.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open testbench/stim_snn.txt");
            record_error();
        end else begin
            while (!timed_out && $fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": begin
                        // comment runs to end of line
                        while (cmd != "\n" && cmd != -1) cmd = $fgetc(fd);
                    end
                    "W": begin
                        cnt = $fscanf(fd, "%d %d %d", a1, a2, a3);
                        check_fields(cnt, 3);
                        program_weight(a1, a2, a3);
                    end
                    "S": begin
                        cnt = $fscanf(fd, "%d", a1);
                        check_fields(cnt, 1);
                        send_input(aer_addr_t'(a1));
                    end
                    "T": send_input(aer_addr_t'(1 << TSTEP_FLAG_BIT));
                    "E": begin
                        cnt = $fscanf(fd, "%h", a1);
                        check_fields(cnt, 1);
                        expect_event(aer_addr_t'(a1));
                    end
                    "G": begin
                        cnt = $fscanf(fd, "%d", a1);
                        check_fields(cnt, 1);
                        expect_goodness(a1);
                    end
                    "N": begin
                        close_test();
                        cnt = $fscanf(fd, "%s", test_name);
                        check_fields(cnt, 1);
                        tests++;
                    end
                    default: begin
                        $display("Error: unknown stim command %c", cmd);
                        record_error();
                    end
                endcase
            end
            $fclose(fd);
        end
        close_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- design/snn_core_top.sv
`timescale 1ns/100ps

module snn_core_top (
    input  logic                 CLK,
    input  logic                 reset,
    // AER input link
    input  snn_pkg::aer_addr_t   aerin_addr,
    input  logic                 aerin_req,
    output logic                 aerin_ack,
    // weight program strobes
    input  logic                 prog_we,
    input  snn_pkg::pre_addr_t   prog_pre,
    input  snn_pkg::post_addr_t  prog_post,
    input  snn_pkg::weight_t     prog_weight,
    // AER output link
    output snn_pkg::aer_addr_t   aerout_addr,
    output logic                 aerout_req,
    input  logic                 aerout_ack,
    // per-sample result
    output snn_pkg::goodness_t   goodness,
    output logic                 sample_done
);
    import snn_pkg::*;

    logic       full, push, push_is_tstep;   // receiver -> scheduler
    pre_addr_t  push_pre;
    logic       pop, empty, head_is_tstep;   // scheduler -> controller
    pre_addr_t  head_pre;
    logic       rd_en;
    pre_addr_t  rd_pre;
    group_t     rd_group;
    syn_word_t  rd_word;
    logic       acc_en, fire_en, sample_end;
    group_t     acc_group, fire_group;
    lane_mask_t fire_mask;
    logic       send, busy;
    aer_addr_t  send_addr;

    // ----------------------------------------------------------------------
    // input side
    // ----------------------------------------------------------------------
    aer_in_receiver aer_in_i (.*);
    event_fifo      fifo_i   (.*);

    // processing
    synapse_mem     syn_i    (.*);
    snn_controller  ctrl_i   (.*);
    neuron_array    neur_i   (.*);

    // output side
    aer_out_sender  aer_out_i (.*);

endmodule

//--- design/aer_out_sender.sv
`timescale 1ns/100ps

module aer_out_sender (
    input  logic                CLK,
    input  logic                reset,
    input  logic                send,
    input  snn_pkg::aer_addr_t  send_addr,
    output logic                busy,
    // four-phase AER output
    output snn_pkg::aer_addr_t  aerout_addr,
    output logic                aerout_req,
    input  logic                aerout_ack
);
    import snn_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,      // ready for send
        S_REQ,       // req high, wait ack
        S_RELEASE    // req low, wait ack low
    } snd_state_t;

    snd_state_t state;
    aer_addr_t  addr_q;

    // ----------------------------------------------------------------------
    // req handshake
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (send)        state <= S_REQ;
                S_REQ:     if (aerout_ack)  state <= S_RELEASE;
                S_RELEASE: if (!aerout_ack) state <= S_IDLE;
                default:                    state <= S_IDLE;
            endcase
        end
    end

    // address held for the whole event
    always_ff @(posedge CLK) begin
        if (send) addr_q <= send_addr;
    end

    assign aerout_addr = addr_q;
    assign aerout_req  = (state == S_REQ);
    assign busy        = (state != S_IDLE);   // until return to zero

    // address steady while req waits for the receiver's ack
    addr_stable_a: assert property (
        @(posedge CLK) disable iff (reset)
        aerout_req && !aerout_ack |=> $stable(aerout_addr)
    );

endmodule

//--- design/neuron_array.sv
`timescale 1ns/100ps

module neuron_array (
    input  logic                 CLK,
    input  logic                 reset,
    input  snn_pkg::syn_word_t   rd_word,
    input  logic                 acc_en,
    input  snn_pkg::group_t      acc_group,
    input  logic                 fire_en,
    input  snn_pkg::group_t      fire_group,
    output snn_pkg::lane_mask_t  fire_mask,
    input  logic                 sample_end,
    output snn_pkg::goodness_t   goodness,
    output logic                 sample_done
);
    import snn_pkg::*;

    membrane_t  v   [N_POST];
    spike_cnt_t cnt [N_POST];

    weight_t   lane_w [N_LANES];
    logic signed [$bits(membrane_t):0] wide [N_LANES];   // one guard bit
    membrane_t acc_v  [N_LANES];
    goodness_t sq_sum;

    // ----------------------------------------------------------------------
    // lane datapath
    // ----------------------------------------------------------------------
    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            lane_w[l] = rd_word[l*$bits(weight_t) +: $bits(weight_t)];
            wide[l]   = v[acc_group*N_LANES + l] + lane_w[l];
            // clamp on overflow of the membrane range
            if (wide[l][$bits(membrane_t)] != wide[l][$bits(membrane_t)-1])
                acc_v[l] = wide[l][$bits(membrane_t)]
                         ? {1'b1, {($bits(membrane_t)-1){1'b0}}}
                         : {1'b0, {($bits(membrane_t)-1){1'b1}}};
            else
                acc_v[l] = wide[l][$bits(membrane_t)-1:0];
            fire_mask[l] = (v[fire_group*N_LANES + l] >= V_THRESH);  // signed
        end
    end

    // goodness, sum of squared counts
    always_comb begin
        sq_sum = '0;
        for (int n = 0; n < N_POST; n++)
            sq_sum += goodness_t'(cnt[n]) * goodness_t'(cnt[n]);
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int n = 0; n < N_POST; n++) begin
                v[n]   <= '0;
                cnt[n] <= '0;
            end
            goodness    <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= sample_end;
            if (sample_end) begin
                goodness <= sq_sum;   // held until next sample end
                for (int n = 0; n < N_POST; n++) begin
                    v[n]   <= '0;
                    cnt[n] <= '0;
                end
            end else if (acc_en) begin
                for (int l = 0; l < N_LANES; l++)
                    v[acc_group*N_LANES + l] <= acc_v[l];
            end else if (fire_en) begin
                for (int l = 0; l < N_LANES; l++) begin
                    if (fire_mask[l]) begin   // reset to zero on fire
                        v[fire_group*N_LANES + l]   <= '0;
                        cnt[fire_group*N_LANES + l] <= cnt[fire_group*N_LANES + l] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- design/snn_controller.sv
`timescale 1ns/100ps

module snn_controller (
    input  logic                 CLK,
    input  logic                 reset,
    // scheduler head
    input  logic                 empty,
    input  logic                 head_is_tstep,
    input  snn_pkg::pre_addr_t   head_pre,
    output logic                 pop,
    // synapse read
    output logic                 rd_en,
    output snn_pkg::pre_addr_t   rd_pre,
    output snn_pkg::group_t      rd_group,
    // neuron strobes
    output logic                 acc_en,
    output snn_pkg::group_t      acc_group,
    output logic                 fire_en,
    output snn_pkg::group_t      fire_group,
    input  snn_pkg::lane_mask_t  fire_mask,
    output logic                 sample_end,
    // output link
    output logic                 send,
    output snn_pkg::aer_addr_t   send_addr,
    input  logic                 busy
);
    import snn_pkg::*;

    ctrl_state_t                state;
    group_t                     grp;       // 0 whenever idle
    tstep_t                     tstep;     // markers seen in this sample
    logic [$clog2(N_LANES)-1:0] lane;      // emit walker
    lane_mask_t                 pending;   // fired lanes of current group
    pre_addr_t                  pre_q;
    logic                       lane_done;
    logic                       last_lane;
    logic                       last_grp;

    assign last_lane = (lane == N_LANES-1);
    assign last_grp  = (grp == group_t'(N_GROUPS-1));
    assign lane_done = !(pending[lane] && busy);   // skip or send this cycle

    // ----------------------------------------------------------------------
    // strobes, decoded from state
    // ----------------------------------------------------------------------
    always_comb begin
        pop        = (state == ST_IDLE) && !empty;
        // group 0 read goes out with the pop
        rd_en      = (pop && !head_is_tstep) || (state == ST_READ);
        rd_pre     = (state == ST_IDLE) ? head_pre : pre_q;
        rd_group   = grp;
        acc_en     = (state == ST_ACC);
        acc_group  = grp;
        fire_en    = (state == ST_EVAL);
        fire_group = grp;
        send       = (state == ST_EMIT) && pending[lane] && !busy;
        send_addr  = aer_addr_t'({tstep, 1'b0, grp, lane});  // step in [5:4]
        sample_end = (state == ST_FINISH) && !busy;          // last event out
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state   <= ST_IDLE;
            grp     <= '0;
            tstep   <= '0;
            lane    <= '0;
            pending <= '0;
        end else begin
            case (state)
                ST_IDLE: if (!empty) state <= head_is_tstep ? ST_EVAL : ST_ACC;
                ST_READ: state <= ST_ACC;
                ST_ACC: begin
                    grp   <= last_grp ? group_t'(0) : grp + 1'b1;
                    state <= last_grp ? ST_IDLE : ST_READ;
                end
                ST_EVAL: begin
                    pending <= fire_mask;   // same mask the array fires on
                    lane    <= '0;
                    state   <= ST_EMIT;
                end
                ST_EMIT: if (lane_done) begin
                    if (!last_lane) begin
                        lane <= lane + 1'b1;
                    end else if (!last_grp) begin
                        grp   <= grp + 1'b1;
                        state <= ST_EVAL;
                    end else begin
                        grp <= '0;
                        if (tstep == tstep_t'(TIME_STEPS-1)) begin
                            state <= ST_FINISH;
                        end else begin
                            tstep <= tstep + 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_FINISH: if (!busy) begin
                    tstep <= '0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // spike input index for the later group reads
    always_ff @(posedge CLK) begin
        if (pop) pre_q <= head_pre;
    end

    // the sender takes each send at once, so the next cycle is busy
    send_then_busy_a: assert property (
        @(posedge CLK) disable iff (reset) send |=> busy
    );

endmodule

//--- design/synapse_mem.sv
`timescale 1ns/100ps

module synapse_mem (
    input  logic                CLK,
    // byte-lane program port
    input  logic                prog_we,
    input  snn_pkg::pre_addr_t  prog_pre,
    input  snn_pkg::post_addr_t prog_post,
    input  snn_pkg::weight_t    prog_weight,
    // word read, data next cycle
    input  logic                rd_en,
    input  snn_pkg::pre_addr_t  rd_pre,
    input  snn_pkg::group_t     rd_group,
    output snn_pkg::syn_word_t  rd_word
);
    import snn_pkg::*;

    // one word per (input, group), address {pre, group}
    syn_word_t mem [N_PRE*N_GROUPS];

    group_t                     wr_group;
    logic [$clog2(N_LANES)-1:0] wr_lane;

    assign {wr_group, wr_lane} = prog_post;   // post = group*4 + lane

    always_ff @(posedge CLK) begin
        if (prog_we) begin
            mem[{prog_pre, wr_group}][wr_lane*$bits(weight_t) +: $bits(weight_t)]
                <= prog_weight;
        end
    end

    // registered read port
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_word <= mem[{rd_pre, rd_group}];
        end
    end

endmodule

//--- design/event_fifo.sv
`timescale 1ns/100ps

module event_fifo (
    input  logic                CLK,
    input  logic                reset,
    input  logic                push,
    input  logic                push_is_tstep,
    input  snn_pkg::pre_addr_t  push_pre,
    input  logic                pop,
    output logic                empty,
    output logic                full,
    output logic                head_is_tstep,
    output snn_pkg::pre_addr_t  head_pre
);
    import snn_pkg::*;

    logic      mem_tstep [FIFO_DEPTH];
    pre_addr_t mem_pre   [FIFO_DEPTH];

    // pointers wrap on their own, depth is a power of two
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   count;   // occupancy 0..FIFO_DEPTH

    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or pass-through
            endcase
        end
    end

    // entry storage
    always_ff @(posedge CLK) begin
        if (push) begin
            mem_tstep[wr_ptr] <= push_is_tstep;
            mem_pre[wr_ptr]   <= push_pre;
        end
    end

    assign empty         = (count == 0);
    assign full          = (count == FIFO_DEPTH);
    assign head_is_tstep = mem_tstep[rd_ptr];  // valid while !empty
    assign head_pre      = mem_pre[rd_ptr];

    // controller must look at empty before it pops
    pop_not_empty_a: assert property (
        @(posedge CLK) disable iff (reset) pop |-> !empty
    );

endmodule

//--- design/aer_in_receiver.sv
`timescale 1ns/100ps

module aer_in_receiver (
    input  logic                CLK,
    input  logic                reset,
    // four-phase AER input
    input  snn_pkg::aer_addr_t  aerin_addr,
    input  logic                aerin_req,
    output logic                aerin_ack,
    // scheduler push side
    input  logic                full,
    output logic                push,
    output logic                push_is_tstep,
    output snn_pkg::pre_addr_t  push_pre
);
    import snn_pkg::*;

    // ----------------------------------------------------------------------
    // ack handshake
    // ----------------------------------------------------------------------
    // ack only rises from low, so one req gives one push
    always_ff @(posedge CLK) begin
        if (reset) begin
            aerin_ack <= 1'b0;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;                       // single cycle strobe
            if (!aerin_ack) begin
                if (aerin_req && !full) begin   // hold off while scheduler full
                    aerin_ack <= 1'b1;
                    push      <= 1'b1;
                end
            end else if (!aerin_req) begin
                aerin_ack <= 1'b0;              // return to zero phase
            end
        end
    end

    // address decode, captured with the ack edge
    always_ff @(posedge CLK) begin
        if (!aerin_ack && aerin_req && !full) begin
            push_is_tstep <= aerin_addr[TSTEP_FLAG_BIT];
            push_pre      <= aerin_addr[$bits(pre_addr_t)-1:0];
        end
    end

    // full is sampled a cycle ahead of the push, so the FIFO must not fill
    // on its own in between
    push_not_full_a: assert property (
        @(posedge CLK) disable iff (reset) push |-> !full
    );

endmodule

//--- design/snn_pkg.sv
package snn_pkg;

    // ----------------------------------------------------------------------
    // network size
    // ----------------------------------------------------------------------
    localparam int N_PRE          = 16;               // input neurons
    localparam int N_POST         = 8;                // output neurons
    localparam int N_LANES        = 4;                // neurons per update
    localparam int N_GROUPS       = N_POST / N_LANES; // lane groups
    localparam int TIME_STEPS     = 4;                // markers per sample
    localparam int V_THRESH       = 64;               // fire level
    localparam int FIFO_DEPTH     = 8;                // scheduler entries

    // AER address layout
    localparam int AER_W          = 12;
    localparam int TSTEP_FLAG_BIT = 11;               // set = time-step marker

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------
    typedef logic [AER_W-1:0]                 aer_addr_t;
    typedef logic [$clog2(N_PRE)-1:0]         pre_addr_t;
    typedef logic [$clog2(N_POST)-1:0]        post_addr_t;
    typedef logic [$clog2(N_GROUPS)-1:0]      group_t;
    typedef logic signed [7:0]                weight_t;
    typedef logic [N_LANES*8-1:0]             syn_word_t;  // lane 0 in low byte
    typedef logic signed [11:0]               membrane_t;
    typedef logic [$clog2(TIME_STEPS):0]      spike_cnt_t; // 0..TIME_STEPS
    typedef logic [$clog2(TIME_STEPS)-1:0]    tstep_t;
    typedef logic [9:0]                       goodness_t;  // max 8 * 4^2 = 128
    typedef logic [N_LANES-1:0]               lane_mask_t;

    // controller sequencing
    typedef enum logic [2:0] {
        ST_IDLE,    // wait for scheduler head
        ST_READ,    // synapse word read, later groups
        ST_ACC,     // integrate one group
        ST_EVAL,    // threshold check of one group
        ST_EMIT,    // walk the fired lanes
        ST_FINISH   // wait for output link, then close sample
    } ctrl_state_t;

endpackage
